// File: dii_pkg.sv
// ======================================================================
// shared widths, buffer depth and arbiter states for the debug merge
// a packet may not be longer than dii_buf_depth flits
// dii_size_w must hold the value dii_buf_depth itself
// ======================================================================

package dii_pkg;

   // payload of one flit
   localparam int dii_data_w = 16;

   // flits held by one packet buffer, also the max packet length
   localparam int dii_buf_depth = 8;

   // packet length in flits, 1 .. dii_buf_depth
   localparam int dii_size_w = 4;

   // arbiter states
   // idle   no packet granted, a choice is made on the next edge
   // fwd_a  forwarding a packet from buffer a
   // fwd_b  forwarding a packet from buffer b
   typedef enum logic [1:0] {
      idle  = 2'd0,
      fwd_a = 2'd1,
      fwd_b = 2'd2
   } arb_state_e;

   // the remaining states are never entered
   // encoding 2'd3 is left unused on purpose so a corrupted
   // state register falls out of every forwarding case

   // source tag driven on out_src
   // 0 means buffer a, 1 means buffer b
   // the arbiter also keeps its last grant in this form

endpackage

// File: dii_flit_if.sv
// ======================================================================
// valid/ready flit channel between buffers and the arbiter
// a flit moves on a rising edge with valid and ready both high
// size is only meaningful on buffer outputs
// ======================================================================

`timescale 1ns/1ns

interface dii_flit_if;
   import dii_pkg::*;

   logic                  valid;  // flit present
   logic                  ready;  // sink accepts
   logic [dii_data_w-1:0] data;   // payload
   logic                  last;   // final flit of its packet
   logic [dii_size_w-1:0] size;   // length of the current packet

   // driving side of the channel
   modport source (
      output valid,
      output data,
      output last,
      output size,
      input  ready
   );

   // receiving side of the channel
   modport sink (
      input  valid,
      input  data,
      input  last,
      input  size,
      output ready
   );

endinterface

// File: dii_buffer.sv
// ======================================================================
// full-packet buffer, a packet shows on out only once its last flit is in
// packets longer than dii_buf_depth never complete and stall the source
// in.size is not read, input packets carry no length
// out.size is the whole length of the oldest complete packet
// ======================================================================

`timescale 1ns/1ns

module dii_buffer (
   input logic        clk,
   input logic        rst,
   dii_flit_if.sink   in,
   dii_flit_if.source out
);
   import dii_pkg::*;

   // shift store, newest flit at index 0
   logic [dii_buf_depth-1:0][dii_data_w-1:0] data;
   logic [dii_buf_depth-1:0] last_buf;     // last marks, shift with data
   logic [dii_buf_depth-1:0] last_shifted; // marks of stored flits, oldest on top

   logic [dii_size_w-1:0] cnt;     // flits stored
   logic [dii_size_w-1:0] cnt_m1;
   logic [$clog2(dii_buf_depth)-1:0] rd_idx; // oldest flit position
   logic [dii_size_w-1:0] sent;    // flits already gone from the head packet
   logic [dii_size_w-1:0] remain;  // flits of the head packet still stored
   logic                  pkt_found;
   logic                  in_fire;
   logic                  out_fire;

   // room left, or one flit leaving makes room this cycle
   assign in.ready = (cnt < dii_buf_depth) || out_fire;
   assign in_fire  = in.valid && in.ready;
   assign out_fire = out.valid && out.ready;

   // fill level
   always_ff @(posedge clk) begin
      if (rst) begin
         cnt <= '0;
      end else if (in_fire && !out_fire) begin
         cnt <= cnt + 1'b1;
      end else if (out_fire && !in_fire) begin
         cnt <= cnt - 1'b1;
      end
   end

   // payload shift, no reset needed
   always_ff @(posedge clk) begin
      if (in_fire) begin
         data <= {data[dii_buf_depth-2:0], in.data};
      end
   end

   // last marks shift in step with the payload
   always_ff @(posedge clk) begin
      if (rst) begin
         last_buf <= '0;
      end else if (in_fire) begin
         last_buf <= {last_buf[dii_buf_depth-2:0], in.last};
      end
   end

   // count of head packet flits already sent, so size holds for the whole packet
   always_ff @(posedge clk) begin
      if (rst) begin
         sent <= '0;
      end else if (out_fire) begin
         sent <= out.last ? '0 : sent + 1'b1;
      end
   end

   assign cnt_m1 = cnt - 1'b1;
   assign rd_idx = cnt_m1[$clog2(dii_buf_depth)-1:0]; // wraps at cnt 0, valid low then

   // drop marks of stale slots above the fill level, oldest ends up at the top bit
   assign last_shifted = last_buf << (dii_buf_depth - cnt);

   // first one from the top is the end of the oldest complete packet
   always_comb begin
      pkt_found = 1'b0;
      remain    = '0;
      for (int i = 0; i < dii_buf_depth; i++) begin
         if (last_shifted[i]) begin
            pkt_found = 1'b1;
            remain    = dii_size_w'(dii_buf_depth - i); // higher i overrides
         end
      end
   end

   assign out.valid = (cnt != '0) && pkt_found;
   assign out.data  = data[rd_idx];
   assign out.last  = last_buf[rd_idx];
   assign out.size  = remain + sent;     // total length, not what is left

   // fill level stays within the store
   a_cnt_range: assert property (@(posedge clk) disable iff (rst)
      cnt <= dii_buf_depth)
      else $error("buffer fill level above depth");

   // a stalled flit keeps its payload even while new flits shift in behind it
   a_data_hold: assert property (@(posedge clk) disable iff (rst)
      out.valid && !out.ready |=> $stable(out.data))
      else $error("buffer output changed under back-pressure");

endmodule

// File: dii_packet_arbiter.sv
// ======================================================================
// round-robin merge of two buffered packet streams, never interleaves
// inputs must come from full-packet buffers, a granted packet is
// assumed to be present to its last flit
// out_src is 0 for a, 1 for b; a wins the first tie after reset
// ======================================================================

`timescale 1ns/1ns

module dii_packet_arbiter (
   input  logic                          clk,
   input  logic                          rst,
   dii_flit_if.sink                      a,
   dii_flit_if.sink                      b,
   output logic                          out_valid,
   output logic [dii_pkg::dii_data_w-1:0] out_data,
   output logic                          out_last,
   output logic                          out_src,
   output logic [dii_pkg::dii_size_w-1:0] out_size,
   input  logic                          out_ready
);
   import dii_pkg::*;

   arb_state_e state;
   arb_state_e state_nxt;
   logic       last_grant;     // 0 a, 1 b
   logic       last_grant_nxt;
   logic       out_fire;
   logic       pick_a;         // round-robin choice in idle

   assign out_fire = out_valid && out_ready;

   // a wins if b is absent or b had the last turn
   assign pick_a = a.valid && (!b.valid || last_grant);

   always_comb begin
      state_nxt      = state;
      last_grant_nxt = last_grant;
      case (state)
         idle: begin
            if (pick_a) begin
               state_nxt      = fwd_a;
               last_grant_nxt = 1'b0;
            end else if (b.valid) begin
               state_nxt      = fwd_b;
               last_grant_nxt = 1'b1;
            end
         end
         fwd_a, fwd_b: begin
            if (out_fire && out_last) begin
               state_nxt = idle;  // packet done, choose again next edge
            end
         end
         default: state_nxt = idle;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state      <= idle;
         last_grant <= 1'b1;  // points to b so a goes first
      end else begin
         state      <= state_nxt;
         last_grant <= last_grant_nxt;
      end
   end

   // steer the granted stream, ready only goes back to that buffer
   always_comb begin
      out_valid = 1'b0;
      out_data  = a.data;
      out_last  = a.last;
      out_src   = last_grant;
      out_size  = a.size;
      a.ready   = 1'b0;
      b.ready   = 1'b0;
      case (state)
         fwd_a: begin
            out_valid = a.valid;
            out_data  = a.data;
            out_last  = a.last;
            out_src   = 1'b0;
            out_size  = a.size;   // buffer keeps it steady for the whole packet
            a.ready   = out_ready;
         end
         fwd_b: begin
            out_valid = b.valid;
            out_data  = b.data;
            out_last  = b.last;
            out_src   = 1'b1;
            out_size  = b.size;
            b.ready   = out_ready;
         end
         default: ;
      endcase
   end

   // source and length stay on the output, stalled or not, until the last flit moves
   a_grant_hold: assert property (@(posedge clk) disable iff (rst)
      out_valid && !(out_ready && out_last) |=>
         out_valid && $stable(out_src) && $stable(out_size))
      else $error("grant or packet size changed before the last flit");

   // buffers only show whole packets, so no gap inside a granted packet
   a_no_gap: assert property (@(posedge clk) disable iff (rst)
      (state != idle) && !(out_fire && out_last) |=> out_valid)
      else $error("granted packet ran dry before its last flit");

endmodule

// File: dii_merge_top.sv
// ======================================================================
// debug merge point, two packet sources into one flit stream
// packets must not exceed dii_buf_depth flits
// out_src 0 marks source a, 1 marks source b
// ======================================================================

`timescale 1ns/1ns

module dii_merge_top (
   input  logic                           clk,
   input  logic                           rst,

   // source a
   input  logic                           a_valid,
   input  logic [dii_pkg::dii_data_w-1:0] a_data,
   input  logic                           a_last,
   output logic                           a_ready,

   // source b
   input  logic                           b_valid,
   input  logic [dii_pkg::dii_data_w-1:0] b_data,
   input  logic                           b_last,
   output logic                           b_ready,

   // merged output
   output logic                           out_valid,
   output logic [dii_pkg::dii_data_w-1:0] out_data,
   output logic                           out_last,
   output logic                           out_src,
   output logic [dii_pkg::dii_size_w-1:0] out_size,
   input  logic                           out_ready
);

   dii_flit_if a_in_if ();   // source a into its buffer
   dii_flit_if b_in_if ();   // source b into its buffer
   dii_flit_if buf_a_if ();  // buffer a to arbiter
   dii_flit_if buf_b_if ();  // buffer b to arbiter

   // input side, size stays open since sources send no length
   assign a_in_if.valid = a_valid;
   assign a_in_if.data  = a_data;
   assign a_in_if.last  = a_last;
   assign a_ready       = a_in_if.ready;

   assign b_in_if.valid = b_valid;
   assign b_in_if.data  = b_data;
   assign b_in_if.last  = b_last;
   assign b_ready       = b_in_if.ready;

   dii_buffer buf_a (
      .clk (clk),
      .rst (rst),
      .in  (a_in_if.sink),
      .out (buf_a_if.source)
   );

   dii_buffer buf_b (
      .clk (clk),
      .rst (rst),
      .in  (b_in_if.sink),
      .out (buf_b_if.source)
   );

   // whole packets only, round robin between a and b
   dii_packet_arbiter arb (
      .clk       (clk),
      .rst       (rst),
      .a         (buf_a_if.sink),
      .b         (buf_b_if.sink),
      .out_valid (out_valid),
      .out_data  (out_data),
      .out_last  (out_last),
      .out_src   (out_src),
      .out_size  (out_size),
      .out_ready (out_ready)
   );

endmodule

// File: tb_dii_merge.sv
// ======================================================================
// testbench for dii_merge_top with random packets on both sources
// packet lengths stay within dii_buf_depth, longer ones would block
// expected packets come from per-source queues filled by the drivers
// ======================================================================

`timescale 1ns/1ns

module tb_dii_merge;
   import dii_pkg::*;

   localparam int flit_timeout  = 2000;   // cycles a source may wait for ready
   localparam int drain_timeout = 4000;
   localparam int fill_timeout  = 400;
   localparam int run_timeout   = 200000;

   logic                  clk;
   logic                  rst;
   logic                  a_valid;
   logic [dii_data_w-1:0] a_data;
   logic                  a_last;
   logic                  a_ready;
   logic                  b_valid;
   logic [dii_data_w-1:0] b_data;
   logic                  b_last;
   logic                  b_ready;
   logic                  out_valid;
   logic [dii_data_w-1:0] out_data;
   logic                  out_last;
   logic                  out_src;
   logic [dii_size_w-1:0] out_size;
   logic                  out_ready;

   // expected traffic, flits and lengths per source
   logic [dii_data_w-1:0] exp_flits_a[$];
   logic [dii_data_w-1:0] exp_flits_b[$];
   int                    exp_lens_a[$];
   int                    exp_lens_b[$];

   int value_err = 0;
   int other_err = 0;
   int pkt_cnt   = 0;   // output packets completed
   int flit_idx  = 0;   // position inside the current output packet
   int cur_len   = 0;
   logic cur_src = 1'b0;
   logic [dii_buf_depth-1:0][dii_data_w-1:0] cur_seq;
   bit   ref_ok    = 1'b0;
   bit   check_alt = 1'b0;  // alternation check window
   bit   prev_alt  = 1'b0;
   logic prev_src  = 1'b0;
   bit   stalling  = 1'b0;

   dii_merge_top dii_merge_top_inst (
      .clk       (clk),
      .rst       (rst),
      .a_valid   (a_valid),
      .a_data    (a_data),
      .a_last    (a_last),
      .a_ready   (a_ready),
      .b_valid   (b_valid),
      .b_data    (b_data),
      .b_last    (b_last),
      .b_ready   (b_ready),
      .out_valid (out_valid),
      .out_data  (out_data),
      .out_last  (out_last),
      .out_src   (out_src),
      .out_size  (out_size),
      .out_ready (out_ready)
   );

   always #4 clk = ~clk;  // 8 ns period

   // expected flits and length of the packet at the head of a source queue
   function automatic int expected_packet(input logic src,
                                          output logic [dii_buf_depth-1:0][dii_data_w-1:0] seq);
      int len;
      seq = '0;
      if (src) begin
         len = exp_lens_b[0];
         for (int i = 0; i < len; i++) seq[i] = exp_flits_b[i];
      end else begin
         len = exp_lens_a[0];
         for (int i = 0; i < len; i++) seq[i] = exp_flits_a[i];
      end
      return len;
   endfunction

   function automatic void drop_packet(input logic src, input int len);
      for (int i = 0; i < len; i++) begin
         if (src) void'(exp_flits_b.pop_front());
         else     void'(exp_flits_a.pop_front());
      end
      if (src) void'(exp_lens_b.pop_front());
      else     void'(exp_lens_a.pop_front());
   endfunction

   task automatic compare_field(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
      assert (got == exp) else begin
         value_err++;
         $display("** Error at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
      end
   endtask

   // a timeout ends the run here
   task automatic abort_run(input string why);
      $display("%0t ns: %s", $time, why);
      $display("errors: value %0d, other %0d, timeout 1", value_err, other_err);
      $display("TESTS FAILED");
      $finish;
   endtask

   // one flit, driven on the falling edge, held until the buffer takes it
   task automatic send_flit(input logic src, input logic [dii_data_w-1:0] d, input logic l);
      int   waited;
      logic taken;
      @(negedge clk);
      if (src) begin
         b_valid = 1'b1;
         b_data  = d;
         b_last  = l;
      end else begin
         a_valid = 1'b1;
         a_data  = d;
         a_last  = l;
      end
      waited = 0;
      taken  = 1'b0;
      while (!taken && waited < flit_timeout) begin
         @(posedge clk);
         taken = src ? b_ready : a_ready;
         waited++;
      end
      if (!taken) abort_run($sformatf("source %0d flit not accepted in time", src));
   endtask

   task automatic release_source(input logic src);
      @(negedge clk);
      if (src) b_valid = 1'b0;
      else     a_valid = 1'b0;
   endtask

   // random packets, queued as expected before the first flit goes out
   task automatic send_packets(input logic src, input int n_pkts, input int max_len,
                               input int max_gap);
      int len;
      int gap;
      logic [dii_buf_depth-1:0][dii_data_w-1:0] pkt;
      for (int p = 0; p < n_pkts; p++) begin
         len = 1 + int'($urandom % max_len);
         for (int i = 0; i < len; i++) begin
            pkt[i] = dii_data_w'($urandom);
            if (src) exp_flits_b.push_back(pkt[i]);
            else     exp_flits_a.push_back(pkt[i]);
         end
         if (src) exp_lens_b.push_back(len);
         else     exp_lens_a.push_back(len);
         for (int i = 0; i < len; i++) send_flit(src, pkt[i], i == len - 1);
         gap = (max_gap > 0) ? int'($urandom % (max_gap + 1)) : 0;
         if (gap > 0) begin
            release_source(src);
            repeat (gap - 1) @(negedge clk);
         end
      end
      release_source(src);
   endtask

   // all queued packets out and no packet open
   task automatic wait_drained(input string phase);
      int waited;
      waited = 0;
      while ((exp_lens_a.size() != 0 || exp_lens_b.size() != 0 || flit_idx != 0)
             && waited < drain_timeout) begin
         @(negedge clk);
         waited++;
      end
      if (waited >= drain_timeout) abort_run({phase, ": packets did not drain in time"});
   endtask

   // output checker, every transfer sampled on the rising edge
   always @(posedge clk) begin
      if (!rst && out_valid && out_ready) begin
         if (flit_idx == 0) begin
            ref_ok = out_src ? (exp_lens_b.size() != 0) : (exp_lens_a.size() != 0);
            if (ref_ok) begin
               cur_len = expected_packet(out_src, cur_seq);
               drop_packet(out_src, cur_len);
               cur_src = out_src;
               if (check_alt && prev_alt) begin
                  assert (out_src != prev_src) else begin
                     other_err++;
                     $display("%0t ns: two packets in a row from source %0d", $time, out_src);
                  end
               end
               prev_src = out_src;
               prev_alt = check_alt;
            end else begin
               other_err++;
               $display("%0t ns: packet from source %0d with none expected", $time, out_src);
            end
         end
         if (ref_ok) begin
            compare_field("out_src", out_src, cur_src);    // no interleaving
            compare_field("out_data", out_data, cur_seq[flit_idx]);
            compare_field("out_size", out_size, cur_len);
            compare_field("out_last", out_last, flit_idx == cur_len - 1);
         end
         if (out_last || (ref_ok && flit_idx == cur_len - 1)) begin
            flit_idx = 0;
            pkt_cnt++;
         end else begin
            flit_idx++;
         end
      end
   end

   initial begin
      int waited;
      int alt_start;
      void'($urandom(50804));
      clk       = 1'b0;
      rst       = 1'b1;
      a_valid   = 1'b0;
      a_data    = '0;
      a_last    = 1'b0;
      b_valid   = 1'b0;
      b_data    = '0;
      b_last    = 1'b0;
      out_ready = 1'b0;
      repeat (5) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      // idle state right after reset
      compare_field("out_valid", out_valid, 1'b0);
      compare_field("a_ready", a_ready, 1'b1);
      compare_field("b_ready", b_ready, 1'b1);
      out_ready = 1'b1;

      // lone packets, a then b
      send_packets(1'b0, 1, dii_buf_depth, 0);
      wait_drained("single packet on a");
      send_packets(1'b1, 1, dii_buf_depth, 0);
      wait_drained("single packet on b");

      // both sources with random back-pressure
      stalling = 1'b1;
      fork
         begin
            fork
               send_packets(1'b0, 40, dii_buf_depth, 3);
               send_packets(1'b1, 40, dii_buf_depth, 3);
            join
            stalling = 1'b0;
         end
         begin
            waited = 0;
            while (stalling && waited < run_timeout) begin
               @(negedge clk);
               out_ready = ($urandom % 4) != 0;
               waited++;
            end
            if (stalling) abort_run("back-pressure phase did not finish");
            out_ready = 1'b1;
         end
      join
      wait_drained("random back-pressure");

      // both buffers stocked with short packets, grants must alternate
      out_ready = 1'b0;
      fork
         send_packets(1'b0, 12, dii_buf_depth / 2, 0);
         send_packets(1'b1, 12, dii_buf_depth / 2, 0);
         begin
            waited = 0;
            while ((a_ready || b_ready) && waited < fill_timeout) begin
               @(posedge clk);
               waited++;
            end
            if (waited >= fill_timeout) abort_run("buffers did not fill under back-pressure");
            @(negedge clk);
            alt_start = pkt_cnt;
            out_ready = 1'b1;
            check_alt = 1'b1;
            waited    = 0;
            while (pkt_cnt < alt_start + 12 && waited < drain_timeout) begin
               @(negedge clk);
               waited++;
            end
            if (waited >= drain_timeout) abort_run("alternation phase stalled");
            check_alt = 1'b0;
         end
      join
      wait_drained("alternation");

      assert (exp_lens_a.size() == 0 && exp_lens_b.size() == 0) else begin
         other_err++;
         $display("packets still expected at the end of the run");
      end
      $display("errors: value %0d, other %0d, timeout 0", value_err, other_err);
      if (value_err == 0 && other_err == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

// File: dii_merge.f
dii_pkg.sv
dii_flit_if.sv
dii_buffer.sv
dii_packet_arbiter.sv
dii_merge_top.sv
tb_dii_merge.sv

// File: Makefile
# Verilator flow for the debug merge point

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing -f dii_merge.f --top-module tb_dii_merge

obj_dir/Vtb_dii_merge: dii_merge.f $(wildcard *.sv)
	verilator --binary --timing --assert -Wno-fatal -f dii_merge.f \
		--top-module tb_dii_merge -Mdir obj_dir -o Vtb_dii_merge

sim: obj_dir/Vtb_dii_merge
	./obj_dir/Vtb_dii_merge 2>&1 | tee sim.log
	@if grep -q "TESTS FAILED" sim.log; then \
		echo "simulation failed"; \
		exit 1; \
	fi
	@if ! grep -q "TESTS PASSED" sim.log; then \
		echo "simulation ended without a result"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
